/* ahb_input_pkg.sv */
// AHB input stage definitions
package ahb_input_pkg;

  // Default bus widths
  parameter int DEF_ADDR_WIDTH   = 32;  // HADDR
  parameter int DEF_MASTER_WIDTH = 4;   // HMASTER

  // HTRANS encoding
  typedef enum logic [1:0] {
    TRN_IDLE   = 2'b00,  // No transfer
    TRN_BUSY   = 2'b01,  // Master wait inside a burst
    TRN_NONSEQ = 2'b10,  // Single or first beat
    TRN_SEQ    = 2'b11   // Remaining burst beats
  } htrans_t;

  // HBURST encoding
  typedef enum logic [2:0] {
    BUR_SINGLE = 3'b000,  // Single transfer
    BUR_INCR   = 3'b001,  // Undefined length
    BUR_WRAP4  = 3'b010,
    BUR_INCR4  = 3'b011,
    BUR_WRAP8  = 3'b100,
    BUR_INCR8  = 3'b101,
    BUR_WRAP16 = 3'b110,
    BUR_INCR16 = 3'b111
  } hburst_t;

  // HSIZE encoding, 128 bits and up handled as byte by the boundary logic
  typedef enum logic [2:0] {
    SIZE_BYTE  = 3'b000,
    SIZE_HALF  = 3'b001,
    SIZE_WORD  = 3'b010,
    SIZE_DWORD = 3'b011,
    SIZE_128   = 3'b100,
    SIZE_256   = 3'b101,
    SIZE_512   = 3'b110,
    SIZE_1024  = 3'b111
  } hsize_t;

  // HRESP encoding
  typedef enum logic [1:0] {
    RSP_OKAY  = 2'b00,
    RSP_ERROR = 2'b01,
    RSP_RETRY = 2'b10,
    RSP_SPLIT = 2'b11
  } hresp_t;

  typedef logic [3:0] hprot_t;  // HPROT bits

endpackage

/* ahb_addr_if.sv */
// AHB address phase bundle
interface ahb_addr_if #(
  parameter int ADDR_WIDTH   = ahb_input_pkg::DEF_ADDR_WIDTH,
  parameter int MASTER_WIDTH = ahb_input_pkg::DEF_MASTER_WIDTH
);
  import ahb_input_pkg::*;

  logic                    sel;       // Slave select
  logic [ADDR_WIDTH-1:0]   addr;      // Transfer address
  htrans_t                 trans;     // Transfer type
  logic                    write;     // Direction, 1 for write
  hsize_t                  size;      // Transfer size
  hburst_t                 burst;     // Burst type
  hprot_t                  prot;      // Protection control
  logic [MASTER_WIDTH-1:0] master;    // Master number
  logic                    mastlock;  // Locked sequence

  // Producer of the phase
  modport src (
    output sel, addr, trans, write, size, burst, prot, master, mastlock
  );

  // Consumers of the phase
  modport snk (
    input sel, addr, trans, write, size, burst, prot, master, mastlock
  );

endinterface

/* ahb_hold_reg.sv */
// AHB holding register and output mux
module ahb_hold_reg #(
  parameter int ADDR_WIDTH   = ahb_input_pkg::DEF_ADDR_WIDTH,
  parameter int MASTER_WIDTH = ahb_input_pkg::DEF_MASTER_WIDTH
) (
  input  logic                     HCLK,
  input  logic                     HRESETn,
  ahb_addr_if.snk                  in_phase,    // Live address phase
  input  logic                     load,        // Capture this phase
  input  logic                     hold_sel,    // Present held phase
  ahb_addr_if.src                  out_phase,   // To output stage
  output ahb_input_pkg::htrans_t   held_trans   // Captured HTRANS
);
  import ahb_input_pkg::*;

  // Held copy of the address phase
  htrans_t                 reg_trans;
  logic [ADDR_WIDTH-1:0]   reg_addr;
  logic                    reg_write;
  hsize_t                  reg_size;
  hburst_t                 reg_burst;
  hprot_t                  reg_prot;
  logic [MASTER_WIDTH-1:0] reg_master;
  logic                    reg_mastlock;

  // -------------------------------------------------------------------------
  // Capture
  // -------------------------------------------------------------------------
  // Trans feeds burst fixup, so it alone comes out of reset as IDLE
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      reg_trans <= TRN_IDLE;
    else if (load)
      reg_trans <= in_phase.trans;
  end

  always_ff @(posedge HCLK)
  begin
    if (load)
    begin
      reg_addr     <= in_phase.addr;
      reg_write    <= in_phase.write;
      reg_size     <= in_phase.size;
      reg_burst    <= in_phase.burst;
      reg_prot     <= in_phase.prot;
      reg_master   <= in_phase.master;
      reg_mastlock <= in_phase.mastlock;
    end
  end

  assign held_trans = reg_trans;

  // -------------------------------------------------------------------------
  // Output mux
  // -------------------------------------------------------------------------
  always_comb
  begin
    if (!hold_sel)
    begin
      out_phase.sel      = in_phase.sel;    // Straight through
      out_phase.trans    = in_phase.trans;
      out_phase.addr     = in_phase.addr;
      out_phase.write    = in_phase.write;
      out_phase.size     = in_phase.size;
      out_phase.burst    = in_phase.burst;
      out_phase.prot     = in_phase.prot;
      out_phase.master   = in_phase.master;
      out_phase.mastlock = in_phase.mastlock;
    end
    else
    begin
      out_phase.sel      = 1'b1;            // Held phase always selected
      out_phase.trans    = TRN_NONSEQ;      // Restarts as a new transfer
      out_phase.addr     = reg_addr;
      out_phase.write    = reg_write;
      out_phase.size     = reg_size;
      out_phase.burst    = reg_burst;
      out_phase.prot     = reg_prot;
      out_phase.master   = reg_master;
      out_phase.mastlock = reg_mastlock;
    end
  end

  // Capture strobe from the control block must be clean
  a_load_known: assert property (@(posedge HCLK) disable iff (!HRESETn)
    !$isunknown(load))
    else $error("load is unknown");

endmodule

/* ahb_hold_ctrl.sv */
// AHB input stage control
module ahb_hold_ctrl (
  input  logic                    HCLK,
  input  logic                    HRESETn,
  ahb_addr_if.snk                 in_phase,      // Live address phase
  input  logic                    HREADYS,       // Bus ready from master side
  input  logic                    active_ip,     // Output stage serving us
  input  logic                    readyout_ip,   // Shared slave HREADY
  input  ahb_input_pkg::hresp_t   resp_ip,       // Shared slave HRESP
  output logic                    load,          // Capture address phase
  output logic                    stall,         // Accepted with no output stage
  output logic                    hold_sel,      // Holding register in use
  output logic                    held_tran_ip,  // Request to arbiter
  output logic                    HREADYOUTS,    // Ready back to master
  output ahb_input_pkg::hresp_t   HRESPS         // Response back to master
);
  import ahb_input_pkg::*;

  logic addr_valid;  // Valid address phase to this port
  logic data_valid;  // Data phase of a valid transfer
  logic pend_next;
  logic pend_q;      // Transfer waiting in holding register

  // -------------------------------------------------------------------------
  // Accept and pending state
  // -------------------------------------------------------------------------
  assign addr_valid = in_phase.sel & in_phase.trans[1];  // NONSEQ or SEQ
  assign load       = addr_valid & HREADYS;
  assign stall      = load & ~active_ip;

  // Set when output stage misses the accept, clear once it completes
  always_comb
  begin
    if (stall)
      pend_next = 1'b1;
    else if (active_ip && readyout_ip)
      pend_next = 1'b0;
    else
      pend_next = pend_q;
  end

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      pend_q <= 1'b0;
    else
      pend_q <= pend_next;
  end

  // Data phase follows address phase only when the bus moves
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      data_valid <= 1'b0;
    else if (HREADYS)
      data_valid <= addr_valid;
  end

  assign hold_sel     = pend_q;
  assign held_tran_ip = load | pend_q;  // Live accept or held transfer

  // -------------------------------------------------------------------------
  // Response return
  // -------------------------------------------------------------------------
  always_comb
  begin
    if (!data_valid)
    begin
      HREADYOUTS = 1'b1;         // Idle, busy or not selected
      HRESPS     = RSP_OKAY;
    end
    else if (pend_q)
    begin
      HREADYOUTS = 1'b0;         // Wait until the held beat is taken
      HRESPS     = RSP_OKAY;
    end
    else
    begin
      HREADYOUTS = readyout_ip;  // Shared slave owns the response
      HRESPS     = resp_ip;
    end
  end

  // Request line rides out any back-pressure from the output stage
  a_pend_req: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (held_tran_ip && !active_ip) |=> held_tran_ip)
    else $error("request dropped while the output stage was elsewhere");

  // Master sees wait states while its beat sits in the holding register
  a_hold_wait: assert property (@(posedge HCLK) disable iff (!HRESETn)
    stall |=> !HREADYOUTS)
    else $error("HREADYOUTS high during held data phase");

endmodule

/* ahb_burst_fixup.sv */
// AHB burst termination and wrap fixup
module ahb_burst_fixup #(
  parameter int ADDR_WIDTH = ahb_input_pkg::DEF_ADDR_WIDTH
) (
  input  logic                     HCLK,
  input  logic                     HRESETn,
  ahb_addr_if.snk                  in_phase,    // Live address phase
  input  logic                     HREADYS,
  input  logic                     load,        // Phase accepted
  input  logic                     stall,       // Accepted without output stage
  input  logic                     hold_sel,    // Holding register in use
  input  ahb_input_pkg::htrans_t   held_trans,  // Captured HTRANS
  input  ahb_input_pkg::htrans_t   mux_trans,   // HTRANS after hold mux
  input  ahb_input_pkg::hburst_t   mux_burst,   // HBURST after hold mux
  output ahb_input_pkg::htrans_t   trans_ip,
  output ahb_input_pkg::hburst_t   burst_ip
);
  import ahb_input_pkg::*;

  logic [ADDR_WIDTH-1:0] beat_addr;
  logic [3:0]            offset_addr;  // Beat index at current size
  logic [3:0]            check_addr;   // Index padded per wrap length
  logic                  override_q;   // Interrupted burst being completed
  logic                  bound_q;      // Last beat of a wrap block seen
  htrans_t               transb;       // Trans used for burst decision

  // -------------------------------------------------------------------------
  // Early burst termination
  // -------------------------------------------------------------------------
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      override_q <= 1'b0;
    else if (HREADYS)
    begin
      if (in_phase.trans == TRN_NONSEQ || in_phase.trans == TRN_IDLE)
        override_q <= 1'b0;  // New burst or end of burst
      else if (in_phase.trans == TRN_SEQ && load && stall)
        override_q <= 1'b1;  // Burst broken mid way
    end
  end

  // -------------------------------------------------------------------------
  // Wrap boundary detection
  // -------------------------------------------------------------------------
  assign beat_addr = in_phase.addr;

  always_comb
  begin
    case (in_phase.size)
      SIZE_HALF:  offset_addr = beat_addr[4:1];
      SIZE_WORD:  offset_addr = beat_addr[5:2];
      SIZE_DWORD: offset_addr = beat_addr[6:3];
      default:    offset_addr = beat_addr[3:0];  // Byte and oversized
    endcase
  end

  always_comb
  begin
    case (in_phase.burst)
      BUR_WRAP4:  check_addr = {2'b11, offset_addr[1:0]};
      BUR_WRAP8:  check_addr = {1'b1, offset_addr[2:0]};
      BUR_WRAP16: check_addr = offset_addr;
      default:    check_addr = 4'b0000;  // INCR and SINGLE never wrap
    endcase
  end

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      bound_q <= 1'b0;
    else if (in_phase.trans[1] && HREADYS)
      bound_q <= &check_addr;
  end

  // -------------------------------------------------------------------------
  // Trans and burst rewrite
  // -------------------------------------------------------------------------
  assign transb = hold_sel ? held_trans : in_phase.trans;

  // SEQ to NONSEQ and BUSY to IDLE past the wrap point
  assign trans_ip = (override_q && bound_q) ? htrans_t'({mux_trans[1], 1'b0})
                                            : mux_trans;
  assign burst_ip = (override_q && transb != TRN_NONSEQ) ? BUR_INCR : mux_burst;

  a_size_legal: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (in_phase.sel && in_phase.trans[1]) |-> (in_phase.size <= SIZE_DWORD))
    else $error("transfer size of 128 bits or more");

endmodule

/* ahb_input_stage.sv */
// AHB bus matrix input stage
module ahb_input_stage #(
  parameter int ADDR_WIDTH   = ahb_input_pkg::DEF_ADDR_WIDTH,
  parameter int MASTER_WIDTH = ahb_input_pkg::DEF_MASTER_WIDTH
) (
  input  logic                     HCLK,
  input  logic                     HRESETn,
  // Master port address phase
  input  logic                     HSELS,
  input  logic [ADDR_WIDTH-1:0]    HADDRS,
  input  ahb_input_pkg::htrans_t   HTRANSS,
  input  logic                     HWRITES,
  input  ahb_input_pkg::hsize_t    HSIZES,
  input  ahb_input_pkg::hburst_t   HBURSTS,
  input  ahb_input_pkg::hprot_t    HPROTS,
  input  logic [MASTER_WIDTH-1:0]  HMASTERS,
  input  logic                     HMASTLOCKS,
  input  logic                     HREADYS,
  // Output stage handshake
  input  logic                     active_ip,
  input  logic                     readyout_ip,
  input  ahb_input_pkg::hresp_t    resp_ip,
  // Master port response
  output logic                     HREADYOUTS,
  output ahb_input_pkg::hresp_t    HRESPS,
  // To output stage
  output logic                     sel_ip,
  output logic [ADDR_WIDTH-1:0]    addr_ip,
  output ahb_input_pkg::htrans_t   trans_ip,
  output logic                     write_ip,
  output ahb_input_pkg::hsize_t    size_ip,
  output ahb_input_pkg::hburst_t   burst_ip,
  output ahb_input_pkg::hprot_t    prot_ip,
  output logic [MASTER_WIDTH-1:0]  master_ip,
  output logic                     mastlock_ip,
  output logic                     held_tran_ip   // Arbiter request
);

  logic                   load;        // Capture strobe
  logic                   stall;       // Accepted, output stage elsewhere
  logic                   hold_sel;    // Holding register selected
  ahb_input_pkg::htrans_t held_trans;

  ahb_addr_if #(.ADDR_WIDTH(ADDR_WIDTH), .MASTER_WIDTH(MASTER_WIDTH)) in_phase ();
  ahb_addr_if #(.ADDR_WIDTH(ADDR_WIDTH), .MASTER_WIDTH(MASTER_WIDTH)) out_phase ();

  // Master port into the bundle
  assign in_phase.sel      = HSELS;
  assign in_phase.addr     = HADDRS;
  assign in_phase.trans    = HTRANSS;
  assign in_phase.write    = HWRITES;
  assign in_phase.size     = HSIZES;
  assign in_phase.burst    = HBURSTS;
  assign in_phase.prot     = HPROTS;
  assign in_phase.master   = HMASTERS;
  assign in_phase.mastlock = HMASTLOCKS;

  ahb_hold_reg #(.ADDR_WIDTH(ADDR_WIDTH), .MASTER_WIDTH(MASTER_WIDTH)) u_hold_reg (
    .HCLK, .HRESETn, .in_phase, .load, .hold_sel, .out_phase, .held_trans
  );

  ahb_hold_ctrl u_hold_ctrl (
    .HCLK, .HRESETn, .in_phase, .HREADYS, .active_ip, .readyout_ip, .resp_ip,
    .load, .stall, .hold_sel, .held_tran_ip, .HREADYOUTS, .HRESPS
  );

  ahb_burst_fixup #(.ADDR_WIDTH(ADDR_WIDTH)) u_burst_fixup (
    .HCLK, .HRESETn, .in_phase, .HREADYS, .load, .stall, .hold_sel, .held_trans,
    .mux_trans(out_phase.trans), .mux_burst(out_phase.burst), .trans_ip, .burst_ip
  );

  // Muxed phase out to the output stage, trans and burst come from fixup
  assign sel_ip      = out_phase.sel;
  assign addr_ip     = out_phase.addr;
  assign write_ip    = out_phase.write;
  assign size_ip     = out_phase.size;
  assign prot_ip     = out_phase.prot;
  assign master_ip   = out_phase.master;
  assign mastlock_ip = out_phase.mastlock;

endmodule

/* tb_clk_gen.sv */
// Testbench clock and reset
module tb_clk_gen #(
  parameter int PERIOD_NS    = 8,   // Clock period
  parameter int RESET_CYCLES = 10   // Cycles with reset held low
) (
  output logic clk,
  output logic rst_n
);
  timeunit 1ns;
  timeprecision 100ps;

  initial
  begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // Synchronous reset, released on a falling edge
  initial
  begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

/* tb_ahb_input_stage.sv */
// AHB input stage testbench
module tb_ahb_input_stage;
  timeunit 1ns;
  timeprecision 100ps;
  import ahb_input_pkg::*;

  localparam int ADDR_W    = DEF_ADDR_WIDTH;
  localparam int MASTER_W  = DEF_MASTER_WIDTH;
  localparam int PERIOD_NS = 8;
  // Cycles for reset and then each directed test in run order
  localparam int TEST_CYCLES = 12 + 2 + 8 + 10 + 12 + 14 + 6;
  localparam int WATCHDOG_NS = 2 * TEST_CYCLES * PERIOD_NS;

  logic                clk;
  logic                rst_n;
  logic                hsel;
  logic [ADDR_W-1:0]   haddr;
  htrans_t             htrans;
  logic                hwrite;
  hsize_t              hsize;
  hburst_t             hburst;
  hprot_t              hprot;
  logic [MASTER_W-1:0] hmaster;
  logic                hmastlock;
  logic                hready;
  logic                active;      // Output stage serving this port
  logic                readyout;    // Shared slave HREADY
  hresp_t              resp;
  logic                hreadyout;
  hresp_t              hresp;
  logic                sel_ip;
  logic [ADDR_W-1:0]   addr_ip;
  htrans_t             trans_ip;
  logic                write_ip;
  hsize_t              size_ip;
  hburst_t             burst_ip;
  hprot_t              prot_ip;
  logic [MASTER_W-1:0] master_ip;
  logic                mastlock_ip;
  logic                held_tran_ip;

  // Copy of the phase that should sit in the holding register
  logic [ADDR_W-1:0]   cap_addr;
  logic                cap_write;
  hsize_t              cap_size;
  hburst_t             cap_burst;
  hprot_t              cap_prot;
  logic [MASTER_W-1:0] cap_master;
  logic                cap_mastlock;

  tb_clk_gen #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(10)) u_clk_gen (.clk, .rst_n);

  ahb_input_stage #(.ADDR_WIDTH(ADDR_W), .MASTER_WIDTH(MASTER_W)) UUT (
    .HCLK(clk), .HRESETn(rst_n), .HSELS(hsel), .HADDRS(haddr), .HTRANSS(htrans),
    .HWRITES(hwrite), .HSIZES(hsize), .HBURSTS(hburst), .HPROTS(hprot),
    .HMASTERS(hmaster), .HMASTLOCKS(hmastlock), .HREADYS(hready),
    .active_ip(active), .readyout_ip(readyout), .resp_ip(resp),
    .HREADYOUTS(hreadyout), .HRESPS(hresp), .sel_ip, .addr_ip, .trans_ip,
    .write_ip, .size_ip, .burst_ip, .prot_ip, .master_ip, .mastlock_ip, .held_tran_ip
  );

  // -------------------------------------------------------------------------
  // Failure handling and compare tasks
  // -------------------------------------------------------------------------
  task automatic abort_run();
    $display("SIMULATION FAILED");
    $fatal(1, "Run stopped at first failure");
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    $display("ERROR: %s = 0x%0h, expected 0x%0h at %0d ns", name, got, exp, $time);
    abort_run();
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
      report_mismatch(name, 64'(got), 64'(exp));
  endtask

  task automatic check_trans(input string name, input htrans_t got, input htrans_t exp);
    if (got !== exp)
      report_mismatch(name, 64'(got), 64'(exp));
  endtask

  task automatic check_burst(input string name, input hburst_t got, input hburst_t exp);
    if (got !== exp)
      report_mismatch(name, 64'(got), 64'(exp));
  endtask

  task automatic check_resp(input string name, input hresp_t got, input hresp_t exp);
    if (got !== exp)
      report_mismatch(name, 64'(got), 64'(exp));
  endtask

  task automatic check_addr(input string name, input logic [ADDR_W-1:0] got,
                            input logic [ADDR_W-1:0] exp);
    if (got !== exp)
      report_mismatch(name, 64'(got), 64'(exp));
  endtask

  task automatic check_size(input string name, input hsize_t got, input hsize_t exp);
    if (got !== exp)
      report_mismatch(name, 64'(got), 64'(exp));
  endtask

  task automatic check_prot(input string name, input hprot_t got, input hprot_t exp);
    if (got !== exp)
      report_mismatch(name, 64'(got), 64'(exp));
  endtask

  task automatic check_master(input string name, input logic [MASTER_W-1:0] got,
                              input logic [MASTER_W-1:0] exp);
    if (got !== exp)
      report_mismatch(name, 64'(got), 64'(exp));
  endtask

  // -------------------------------------------------------------------------
  // Stimulus helpers
  // -------------------------------------------------------------------------
  // Random address aligned to one WRAP4 word block
  function automatic logic [ADDR_W-1:0] block_base();
    return ADDR_W'($urandom) & ~ADDR_W'(15);
  endfunction

  task automatic drive_idle();
    hsel     = 1'b0;
    htrans   = TRN_IDLE;
    hready   = 1'b1;
    active   = 1'b1;
    readyout = 1'b1;
    resp     = RSP_OKAY;
  endtask

  task automatic drive_phase(input logic sel, input htrans_t trans,
                             input logic [ADDR_W-1:0] addr, input hburst_t burst);
    hsel      = sel;
    htrans    = trans;
    haddr     = addr;
    hburst    = burst;
    hsize     = SIZE_WORD;           // Word beats throughout
    hwrite    = 1'($urandom);
    hprot     = hprot_t'($urandom);
    hmaster   = MASTER_W'($urandom);
    hmastlock = 1'($urandom);
  endtask

  // Every _ip output equal to its input in the same cycle
  task automatic check_passthrough();
    check_bit("sel_ip", sel_ip, hsel);
    check_addr("addr_ip", addr_ip, haddr);
    check_trans("trans_ip", trans_ip, htrans);
    check_bit("write_ip", write_ip, hwrite);
    check_size("size_ip", size_ip, hsize);
    check_burst("burst_ip", burst_ip, hburst);
    check_prot("prot_ip", prot_ip, hprot);
    check_master("master_ip", master_ip, hmaster);
    check_bit("mastlock_ip", mastlock_ip, hmastlock);
  endtask

  // Accept cycle while the output stage is elsewhere
  task automatic accept_stalled();
    active = 1'b0;
    #1;
    check_passthrough();
    check_bit("held_tran_ip", held_tran_ip, 1'b1);
    cap_addr     = haddr;
    cap_write    = hwrite;
    cap_size     = hsize;
    cap_burst    = hburst;
    cap_prot     = hprot;
    cap_master   = hmaster;
    cap_mastlock = hmastlock;
  endtask

  // Master stalled, inputs wander, outputs stay on the captured phase
  task automatic hold_cycles(input int n, input htrans_t exp_trans, input hburst_t exp_burst);
    repeat (n)
    begin
      @(negedge clk);
      drive_phase(1'b1, htrans_t'($urandom), block_base(), hburst_t'($urandom));
      hready = 1'b0;
      active = 1'b0;
      #1;
      check_bit("sel_ip", sel_ip, 1'b1);
      check_trans("trans_ip", trans_ip, exp_trans);
      check_burst("burst_ip", burst_ip, exp_burst);
      check_addr("addr_ip", addr_ip, cap_addr);
      check_bit("write_ip", write_ip, cap_write);
      check_size("size_ip", size_ip, cap_size);
      check_prot("prot_ip", prot_ip, cap_prot);
      check_master("master_ip", master_ip, cap_master);
      check_bit("mastlock_ip", mastlock_ip, cap_mastlock);
      check_bit("HREADYOUTS", hreadyout, 1'b0);
      check_bit("held_tran_ip", held_tran_ip, 1'b1);
    end
  endtask

  // Output stage takes the held beat, then the request line drops
  task automatic release_hold();
    int waited;
    waited = 0;
    @(negedge clk);
    active   = 1'b1;
    readyout = 1'b1;
    #1;
    check_bit("held_tran_ip", held_tran_ip, 1'b1);
    @(negedge clk);
    while (held_tran_ip)
    begin
      waited++;
      if (waited > 4)
      begin
        $display("Held transfer was not released within 4 cycles");
        abort_run();
      end
      @(negedge clk);
    end
  endtask

  // -------------------------------------------------------------------------
  // Directed tests
  // -------------------------------------------------------------------------
  task automatic test_reset_state();
    drive_idle();
    #1;
    check_bit("HREADYOUTS", hreadyout, 1'b1);
    check_resp("HRESPS", hresp, RSP_OKAY);
    check_bit("held_tran_ip", held_tran_ip, 1'b0);
    @(negedge clk);
  endtask

  task automatic test_pass_through();
    repeat (3)
    begin
      drive_phase(1'b1, TRN_NONSEQ, block_base() + 4, hburst_t'($urandom));
      #1;
      check_passthrough();
      check_bit("held_tran_ip", held_tran_ip, 1'b1);
      @(negedge clk);
    end
    // Two cycle ERROR response on the last beat
    drive_idle();
    hready   = 1'b0;
    readyout = 1'b0;
    resp     = RSP_ERROR;
    #1;
    check_bit("HREADYOUTS", hreadyout, 1'b0);
    check_resp("HRESPS", hresp, RSP_ERROR);
    @(negedge clk);
    hready   = 1'b1;
    readyout = 1'b1;
    #1;
    check_bit("HREADYOUTS", hreadyout, 1'b1);
    check_resp("HRESPS", hresp, RSP_ERROR);
    @(negedge clk);
    drive_idle();
  endtask

  task automatic test_held_transfer();
    drive_phase(1'b1, TRN_NONSEQ, block_base() + 8, hburst_t'($urandom));
    accept_stalled();
    hold_cycles(3, TRN_NONSEQ, cap_burst);
    release_hold();
    drive_phase(1'b0, TRN_IDLE, block_base(), hburst_t'($urandom));
    hready = 1'b1;
    #1;
    check_passthrough();                  // Back on the live inputs
    check_bit("held_tran_ip", held_tran_ip, 1'b0);
    @(negedge clk);
    drive_idle();
    @(negedge clk);
  endtask

  task automatic test_burst_termination();
    logic [ADDR_W-1:0] base;
    base = block_base();
    drive_phase(1'b1, TRN_NONSEQ, base, BUR_INCR4);
    #1;
    check_passthrough();
    @(negedge clk);
    drive_phase(1'b1, TRN_SEQ, base + 4, BUR_INCR4);
    accept_stalled();
    hold_cycles(2, TRN_NONSEQ, BUR_INCR);  // Broken INCR4 restarts as INCR
    release_hold();
    drive_phase(1'b1, TRN_SEQ, base + 8, BUR_INCR4);
    hready = 1'b1;
    #1;
    check_trans("trans_ip", trans_ip, TRN_SEQ);
    check_burst("burst_ip", burst_ip, BUR_INCR);
    @(negedge clk);
    drive_idle();
    @(negedge clk);
  endtask

  task automatic test_wrap_boundary();
    logic [ADDR_W-1:0] base;
    base = block_base();
    drive_phase(1'b1, TRN_NONSEQ, base + 4, BUR_WRAP4);
    #1;
    check_passthrough();
    @(negedge clk);
    drive_phase(1'b1, TRN_SEQ, base + 8, BUR_WRAP4);
    #1;
    check_passthrough();
    @(negedge clk);
    drive_phase(1'b1, TRN_SEQ, base + 12, BUR_WRAP4);  // Beat index 2'b11
    accept_stalled();
    hold_cycles(2, TRN_NONSEQ, BUR_INCR);
    release_hold();
    drive_phase(1'b1, TRN_BUSY, base, BUR_WRAP4);
    hready = 1'b1;
    #1;
    check_trans("trans_ip", trans_ip, TRN_IDLE);       // BUSY past the wrap
    @(negedge clk);
    drive_phase(1'b1, TRN_SEQ, base, BUR_WRAP4);
    #1;
    check_trans("trans_ip", trans_ip, TRN_NONSEQ);     // Wrapped beat restarts
    check_burst("burst_ip", burst_ip, BUR_INCR);
    @(negedge clk);
    drive_idle();
    @(negedge clk);
  endtask

  task automatic test_idle_unselected();
    for (int i = 0; i < 4; i++)
    begin
      drive_phase(i[0], (i[0] ? TRN_IDLE : TRN_NONSEQ), block_base(), BUR_SINGLE);
      active   = i[1];
      readyout = 1'($urandom);
      resp     = RSP_ERROR;                // Must not reach the master
      #1;
      check_bit("HREADYOUTS", hreadyout, 1'b1);
      check_resp("HRESPS", hresp, RSP_OKAY);
      check_bit("held_tran_ip", held_tran_ip, 1'b0);
      @(negedge clk);
    end
    drive_idle();
  endtask

  // -------------------------------------------------------------------------
  // Sequencer and watchdog
  // -------------------------------------------------------------------------
  initial
  begin
    drive_idle();
    haddr     = '0;
    hwrite    = 1'b0;
    hsize     = SIZE_WORD;
    hburst    = BUR_SINGLE;
    hprot     = '0;
    hmaster   = '0;
    hmastlock = 1'b0;
    void'($urandom(32'he475_8aae));
    wait (rst_n === 1'b1);
    test_reset_state();
    test_pass_through();
    test_held_transfer();
    test_burst_termination();
    test_wrap_boundary();
    test_idle_unselected();
    $display("SIMULATION PASSED");
    $finish;
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("Watchdog expired, tests did not finish within %0d ns", WATCHDOG_NS);
    abort_run();
  end

endmodule

/* src.f */
ahb_input_pkg.sv
ahb_addr_if.sv
ahb_hold_reg.sv
ahb_hold_ctrl.sv
ahb_burst_fixup.sv
ahb_input_stage.sv
tb_clk_gen.sv
tb_ahb_input_stage.sv

/* run.sh */
#!/bin/sh
# Builds and runs the AHB input stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert --timescale 1ns/100ps \
  -f src.f --top-module tb_ahb_input_stage --Mdir "$OBJ" -o sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ/sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

# Result is taken from the log
if grep -q "^SIMULATION PASSED$" "$LOG"; then
  exit 0
fi
echo "Pass line not found in $LOG"
exit 1
